//--- common/corr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// correlator datapath types.
// counters, delay line taps and the integration window length.
////////////////////////////////////////////////////////////////////////////

`include "xcorr_config.svh"

package corr_pkg;

	// one coincidence count.
	typedef logic [`XCORR_COUNT_WIDTH-1:0] count_t;

	// delay line, tap 0 newest, each tap one bit per input.
	typedef logic [`XCORR_MAX_LAG-1:0][`XCORR_NUM_INPUTS-1:0] lag_taps_t;

	// window length in cycles.
	typedef logic [15:0] window_t;

	// counter lanes, one per input and lag.
	localparam int NUM_LANES = `XCORR_NUM_INPUTS * `XCORR_MAX_LAG;

	// index width for selecting a lane.
	localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	localparam window_t MIN_WINDOW = window_t'(`XCORR_MIN_WINDOW);

endpackage

//--- common/wb_regs_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone register port of the autocorrelator.
// bus types, register addresses and bit positions.
////////////////////////////////////////////////////////////////////////////

`include "xcorr_config.svh"

package wb_regs_pkg;

	typedef logic [7:0] wb_addr_t; // byte address.
	typedef logic [31:0] wb_data_t;

	// control, bit 0 enables integration.
	localparam wb_addr_t REG_CTRL = 8'h00;
	localparam int CTRL_ENABLE_BIT = 0;

	// window length in cycles.
	localparam wb_addr_t REG_WINDOW = 8'h04;

	// ready flag and frame number.
	localparam wb_addr_t REG_STATUS = 8'h08;
	localparam int STATUS_READY_BIT = 0;
	localparam int STATUS_FRAME_LSB = 8;

	// result words, input-major then lag.
	localparam wb_addr_t REG_RESULT_BASE = 8'h10;

	// first address past the result bank.
	localparam wb_addr_t REG_RESULT_END =
		REG_RESULT_BASE + wb_addr_t'(4 * `XCORR_NUM_INPUTS * `XCORR_MAX_LAG);

endpackage

//--- common/xcorr_config.svh
////////////////////////////////////////////////////////////////////////////
// pulse-train autocorrelator build constants.
// sizes of the input set, the lag range and the counters, and the
// shortest integration window that the register port accepts.
////////////////////////////////////////////////////////////////////////////

`ifndef XCORR_CONFIG_SVH
`define XCORR_CONFIG_SVH

// pulse lines sampled in parallel.
`define XCORR_NUM_INPUTS 2

// lags per input, lag 0 included.
`define XCORR_MAX_LAG 4

// bits per coincidence counter.
`define XCORR_COUNT_WIDTH 8

// shorter windows are raised to this.
`define XCORR_MIN_WINDOW 16

`endif

//--- correlator/lag_counter.sv
////////////////////////////////////////////////////////////////////////////
// lag counter.
// counts the cycles where a line and its delayed copy are both high,
// saturating at all ones, and restarts from the live hit on frame end.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lag_counter
	import corr_pkg::*;
(
	input  logic   integration_clk,
	input  logic   arst_n,
	input  logic   newest,
	input  logic   delayed,
	input  logic   frame_end,
	output count_t count
);

	logic   hit;
	count_t count_q;

	assign hit = newest & delayed; // coincidence this cycle.

	always_ff @(posedge integration_clk or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else if (frame_end) begin
			// old value goes to the result bank on this edge,
			// the current hit opens the next frame.
			count_q <= count_t'(hit);
		end else if (hit && (count_q != '1)) begin
			count_q <= count_q + 1'b1;
		end
	end

	assign count = count_q;

endmodule

//--- correlator/pulse_delay_line.sv
////////////////////////////////////////////////////////////////////////////
// pulse delay line.
// samples the pulse lines each cycle into tap 0 and shifts older
// samples down, so tap k holds the sample from k edges earlier.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "xcorr_config.svh"

module pulse_delay_line
	import corr_pkg::*;
(
	input  logic                         integration_clk,
	input  logic                         arst_n,
	input  logic [`XCORR_NUM_INPUTS-1:0] line_in,
	output lag_taps_t                    taps
);

	lag_taps_t taps_q;

	always_ff @(posedge integration_clk or negedge arst_n) begin
		if (!arst_n) begin
			taps_q <= '0;
		end else begin
			taps_q[0] <= line_in; // sampling stage.
			for (int k = 1; k < `XCORR_MAX_LAG; k++) begin
				taps_q[k] <= taps_q[k-1];
			end
		end
	end

	// every counter reads the same taps.
	assign taps = taps_q;

endmodule

//--- logic/integration_timer.sv
////////////////////////////////////////////////////////////////////////////
// integration timer.
// counts cycles while enabled and pulses frame_end on the last cycle
// of each window. restart or a low enable returns to window start.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module integration_timer
	import corr_pkg::*;
(
	input  logic    integration_clk,
	input  logic    arst_n,
	input  logic    enable,
	input  window_t window,
	input  logic    restart,
	output logic    frame_end
);

	window_t cycle_cnt; // cycles elapsed in this window.
	logic    last_cycle;

	// window is never below the minimum, so window-1 cannot wrap.
	assign last_cycle = (cycle_cnt == (window - 1'b1));

	assign frame_end = enable & last_cycle;

	always_ff @(posedge integration_clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle_cnt <= '0;
		end else if (!enable || restart) begin
			cycle_cnt <= '0; // hold at window start.
		end else if (last_cycle) begin
			cycle_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

endmodule

//--- logic/wb_result_readout.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone classic slave for the autocorrelator.
// control and window registers, a result bank loaded on frame end,
// and a ready flag with frame number that a status read clears.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module wb_result_readout
	import corr_pkg::*;
	import wb_regs_pkg::*;
(
	input  logic                     integration_clk,
	input  logic                     arst_n,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  wb_addr_t                 wb_adr,
	input  wb_data_t                 wb_dat_w,
	output wb_data_t                 wb_dat_r,
	output logic                     wb_ack,
	input  count_t [NUM_LANES-1:0]   counts,
	input  logic                     frame_end,
	output logic                     enable,
	output window_t                  window,
	output logic                     window_restart,
	output logic                     irq
);

	logic                  req;
	logic                  wr_req;
	logic                  rd_req;
	logic                  status_rd;
	logic                  ready;
	logic [7:0]            frame_num;
	count_t [NUM_LANES-1:0] results;
	window_t               wr_window;
	wb_addr_t              result_offs;
	logic                  result_hit;
	wb_data_t              rd_data;

	// one request per transfer, the held strobe is ignored while acked.
	assign req    = wb_cyc & wb_stb & ~wb_ack;
	assign wr_req = req & wb_we;
	assign rd_req = req & ~wb_we;

	assign status_rd      = rd_req && (wb_adr == REG_STATUS);
	assign window_restart = wr_req && (wb_adr == REG_WINDOW);

	// clamp short windows.
	assign wr_window = (wb_dat_w[15:0] < MIN_WINDOW) ? MIN_WINDOW : wb_dat_w[15:0];

	assign result_offs = wb_adr - REG_RESULT_BASE;
	assign result_hit  = (wb_adr >= REG_RESULT_BASE) && (wb_adr < REG_RESULT_END) &&
		(wb_adr[1:0] == 2'b00);

	always_comb begin
		rd_data = '0; // unmapped reads zero.
		if (wb_adr == REG_CTRL) begin
			rd_data[CTRL_ENABLE_BIT] = enable;
		end else if (wb_adr == REG_WINDOW) begin
			rd_data[15:0] = window;
		end else if (wb_adr == REG_STATUS) begin
			rd_data[STATUS_READY_BIT] = ready;
			rd_data[STATUS_FRAME_LSB +: 8] = frame_num;
		end else if (result_hit) begin
			rd_data[$bits(count_t)-1:0] = results[result_offs[2 +: LANE_IDX_W]];
		end
	end

	always_ff @(posedge integration_clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack    <= 1'b0;
			enable    <= 1'b0;
			window    <= MIN_WINDOW;
			ready     <= 1'b0;
			frame_num <= '0;
			results   <= '0;
		end else begin
			wb_ack <= req;
			if (wr_req && (wb_adr == REG_CTRL)) begin
				enable <= wb_dat_w[CTRL_ENABLE_BIT];
			end
			if (window_restart) begin
				window <= wr_window;
			end
			if (frame_end) begin
				results   <= counts; // pre-update counter values.
				frame_num <= frame_num + 1'b1;
				ready     <= 1'b1; // wins over a status read.
			end else if (status_rd) begin
				ready <= 1'b0;
			end
		end
	end

	// read data held while ack is high.
	always_ff @(posedge integration_clk) begin
		if (rd_req) begin
			wb_dat_r <= rd_data;
		end
	end

	assign irq = ready;

endmodule

//--- logic/xcorr_top.sv
////////////////////////////////////////////////////////////////////////////
// pulse-train autocorrelator top level.
// delay line, one saturating counter per input and lag, the window
// timer and the Wishbone result port.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "xcorr_config.svh"

module xcorr_top
	import corr_pkg::*;
	import wb_regs_pkg::*;
(
	input  logic                         integration_clk,
	input  logic                         arst_n,
	input  logic [`XCORR_NUM_INPUTS-1:0] line_in,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  wb_addr_t                     wb_adr,
	input  wb_data_t                     wb_dat_w,
	output wb_data_t                     wb_dat_r,
	output logic                         wb_ack,
	output logic                         irq
);

	lag_taps_t              taps;
	count_t [NUM_LANES-1:0] counts;
	logic                   frame_end;
	logic                   enable;
	window_t                window;
	logic                   window_restart;

	pulse_delay_line u_delay (
		.integration_clk (integration_clk),
		.arst_n          (arst_n),
		.line_in         (line_in),
		.taps            (taps)
	);

	// lane i*MAX_LAG+k compares input i with itself k samples back.
	for (genvar i = 0; i < `XCORR_NUM_INPUTS; i++) begin : g_input
		for (genvar k = 0; k < `XCORR_MAX_LAG; k++) begin : g_lag
			lag_counter u_cnt (
				.integration_clk (integration_clk),
				.arst_n          (arst_n),
				.newest          (taps[0][i]),
				.delayed         (taps[k][i]),
				.frame_end       (frame_end),
				.count           (counts[i*`XCORR_MAX_LAG + k])
			);
		end
	end

	integration_timer u_timer (
		.integration_clk (integration_clk),
		.arst_n          (arst_n),
		.enable          (enable),
		.window          (window),
		.restart         (window_restart),
		.frame_end       (frame_end)
	);

	wb_result_readout u_regs (
		.integration_clk (integration_clk),
		.arst_n          (arst_n),
		.wb_cyc          (wb_cyc),
		.wb_stb          (wb_stb),
		.wb_we           (wb_we),
		.wb_adr          (wb_adr),
		.wb_dat_w        (wb_dat_w),
		.wb_dat_r        (wb_dat_r),
		.wb_ack          (wb_ack),
		.counts          (counts),
		.frame_end       (frame_end),
		.enable          (enable),
		.window          (window),
		.window_restart  (window_restart),
		.irq             (irq)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the autocorrelator testbench with Verilator and runs it.
# The exit status is the simulation's own.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=xcorr_sim

verilator --binary --timing --assert \
	--top-module xcorr_tb \
	-f src.f \
	--Mdir "${build_dir}" \
	-o "${sim_bin}"
status=$?
if [ ${status} -ne 0 ]; then
	echo "verilator build failed with status ${status}"
	exit ${status}
fi

"./${build_dir}/${sim_bin}"
status=$?
if [ ${status} -ne 0 ]; then
	echo "simulation exited with status ${status}"
	exit ${status}
fi

exit 0

//--- src.f
+incdir+common
common/corr_pkg.sv
common/wb_regs_pkg.sv
correlator/pulse_delay_line.sv
correlator/lag_counter.sv
logic/integration_timer.sv
logic/wb_result_readout.sv
logic/xcorr_top.sv
verif/tb_clock_gen.sv
verif/xcorr_props.sv
verif/xcorr_tb.sv

//--- verif/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset generator.
// free-running clock and an active-low reset held for a few cycles.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 3
) (
	output logic integration_clk,
	output logic arst_n
);

	initial begin
		integration_clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) integration_clk = ~integration_clk;
		end
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge integration_clk);
		#1 arst_n = 1'b1; // release away from the edge.
	end

endmodule

//--- verif/xcorr_props.sv
////////////////////////////////////////////////////////////////////////////
// autocorrelator register port properties.
// ack timing, irq clearing and the window lower bound.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module xcorr_props
	import corr_pkg::*;
	import wb_regs_pkg::*;
(
	input logic     integration_clk,
	input logic     arst_n,
	input logic     wb_cyc,
	input logic     wb_stb,
	input logic     wb_we,
	input wb_addr_t wb_adr,
	input logic     wb_ack,
	input logic     irq,
	input window_t  window
);

	ack_follows_strobe: assert property (@(posedge integration_clk) disable iff (!arst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without a pending strobe");

	ack_single_cycle: assert property (@(posedge integration_clk) disable iff (!arst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held longer than one cycle");

	// ready only drops on the ack edge of a status read.
	irq_clears_on_status_read: assert property (@(posedge integration_clk)
		disable iff (!arst_n)
		$fell(irq) |-> (wb_ack && $past(!wb_we && (wb_adr == REG_STATUS))))
		else $error("irq fell without a status read");

	// write lands on the ack edge.
	window_not_below_min: assert property (@(posedge integration_clk) disable iff (!arst_n)
		(wb_ack && $past(wb_we && (wb_adr == REG_WINDOW))) |-> (window >= MIN_WINDOW))
		else $error("window register below the minimum");

endmodule

bind wb_result_readout xcorr_props props_i (
	.integration_clk (integration_clk),
	.arst_n          (arst_n),
	.wb_cyc          (wb_cyc),
	.wb_stb          (wb_stb),
	.wb_we           (wb_we),
	.wb_adr          (wb_adr),
	.wb_ack          (wb_ack),
	.irq             (irq),
	.window          (window)
);

//--- verif/xcorr_tb.sv
////////////////////////////////////////////////////////////////////////////
// autocorrelator testbench.
// random pulse bursts per frame read back over Wishbone and compared
// with a reference count, plus window, status and saturation checks.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "xcorr_config.svh"

module xcorr_tb
	import corr_pkg::*;
	import wb_regs_pkg::*;
();

	localparam int CLK_PERIOD_NS   = 4;
	localparam int DRIVE_DELAY_NS  = 1;
	localparam int RAND_FRAMES     = 4;
	localparam int RAND_WINDOW     = 128;
	localparam int BURST_LEN       = 64;
	localparam int GUARD_CYCLES    = `XCORR_MAX_LAG + 2;
	localparam int SAT_WINDOW      = 400;
	localparam int ACK_LIMIT       = 8;
	// random frames, two saturation frames, three idle windows.
	localparam int WATCHDOG_CYCLES = RAND_FRAMES * RAND_WINDOW + 5 * SAT_WINDOW + 2000;

	typedef logic [`XCORR_NUM_INPUTS-1:0] sample_t;
	typedef sample_t sample_q_t[$];

	logic     integration_clk;
	logic     arst_n;
	sample_t  line_in;
	logic     wb_cyc;
	logic     wb_stb;
	logic     wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic     wb_ack;
	logic     irq;

	sample_t    frame_samples[$]; // bursts back to back.
	int         frame_lens[$];
	count_t     observed_q[$];    // read counts in lane order.
	int         frames_compared = 0;
	logic [7:0] frame_no;

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) clk_gen_i (
		.integration_clk (integration_clk),
		.arst_n          (arst_n)
	);

	xcorr_top dut_i (
		.integration_clk (integration_clk),
		.arst_n          (arst_n),
		.line_in         (line_in),
		.wb_cyc          (wb_cyc),
		.wb_stb          (wb_stb),
		.wb_we           (wb_we),
		.wb_adr          (wb_adr),
		.wb_dat_w        (wb_dat_w),
		.wb_dat_r        (wb_dat_r),
		.wb_ack          (wb_ack),
		.irq             (irq)
	);

	// coincidences of bit i with itself k samples back, saturating.
	function automatic count_t expected_count(input sample_q_t samples, input int i, input int k);
		int hits;
		int sat;
		hits = 0;
		sat  = (1 << `XCORR_COUNT_WIDTH) - 1;
		for (int j = k; j < samples.size(); j++) begin
			if (samples[j][i] && samples[j-k][i]) begin
				hits++;
			end
		end
		if (hits > sat) begin
			hits = sat;
		end
		return count_t'(hits);
	endfunction

	task automatic report_error(input string msg);
		$display("[ERROR] %0d ns: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_count(input string what, input count_t got, input count_t exp);
		if (got !== exp) begin
			report_error($sformatf("%s: count %0d, expected %0d", what, got, exp));
		end
	endtask

	task automatic check_status(input string what, input wb_data_t got, input wb_data_t exp);
		if (got !== exp) begin
			report_error($sformatf("%s: read 0x%08h, expected 0x%08h", what, got, exp));
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			report_error($sformatf("%s: flag %b, expected %b", what, got, exp));
		end
	endtask

	// to the drive point of the next cycle.
	task automatic next_cycle();
		@(posedge integration_clk);
		#DRIVE_DELAY_NS;
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			next_cycle();
			n++;
			if (n > ACK_LIMIT) begin
				abort_run("bus hang: no wb_ack after a request");
			end
		end while (!wb_ack);
	endtask

	task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = addr;
		wb_dat_w = data;
		wait_ack();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = addr;
		wait_ack();
		data   = wb_dat_r; // valid while ack is high.
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic read_lane(input int lane, output count_t cnt);
		wb_data_t data;
		wb_read(REG_RESULT_BASE + wb_addr_t'(4 * lane), data);
		check_status($sformatf("lane %0d upper bits", lane), data >> `XCORR_COUNT_WIDTH,
			wb_data_t'(0));
		cnt = count_t'(data);
	endtask

	task automatic expect_status(input logic ready, input logic [7:0] frame);
		wb_data_t data;
		wb_data_t exp;
		exp = '0;
		exp[STATUS_READY_BIT] = ready;
		exp[STATUS_FRAME_LSB +: 8] = frame;
		wb_read(REG_STATUS, data);
		check_status("status word", data, exp);
	endtask

	task automatic drive_burst(input int len);
		sample_t s;
		frame_lens.push_back(len);
		for (int n = 0; n < len; n++) begin
			s       = sample_t'($urandom);
			line_in = s;
			frame_samples.push_back(s);
			next_cycle();
		end
		line_in = '0;
	endtask

	task automatic wait_frame();
		while (!irq) begin
			next_cycle();
		end
	endtask

	// one frame of counts against the reference.
	always @(posedge integration_clk) begin : compare_frames
		sample_q_t samples;
		int        len;
		if (observed_q.size() >= NUM_LANES) begin
			len     = frame_lens.pop_front();
			samples = {};
			repeat (len) begin
				samples.push_back(frame_samples.pop_front());
			end
			for (int i = 0; i < `XCORR_NUM_INPUTS; i++) begin
				for (int k = 0; k < `XCORR_MAX_LAG; k++) begin
					check_count($sformatf("frame %0d input %0d lag %0d", frames_compared + 1, i, k),
						observed_q.pop_front(), expected_count(samples, i, k));
				end
			end
			frames_compared++;
		end
	end

	initial begin : stimulus
		wb_data_t data;
		count_t   cnt;
		void'($urandom(32'h1950));
		line_in  = '0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		frame_no = '0;
		wait (arst_n === 1'b1);
		next_cycle();

		check_flag("irq after reset", irq, 1'b0);
		expect_status(1'b0, frame_no);
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			read_lane(lane, cnt);
			check_count($sformatf("lane %0d after reset", lane), cnt, count_t'(0));
		end

		wb_write(REG_WINDOW, wb_data_t'(5));
		wb_read(REG_WINDOW, data);
		check_status("short window", data, wb_data_t'(`XCORR_MIN_WINDOW));
		wb_write(REG_WINDOW, wb_data_t'(100));
		wb_read(REG_WINDOW, data);
		check_status("legal window", data, wb_data_t'(100));

		// bursts kept clear of both window edges.
		wb_write(REG_WINDOW, wb_data_t'(RAND_WINDOW));
		wb_write(REG_CTRL, wb_data_t'(1));
		for (int f = 0; f < RAND_FRAMES; f++) begin
			repeat (GUARD_CYCLES) next_cycle();
			drive_burst(BURST_LEN);
			repeat (GUARD_CYCLES) next_cycle();
			wait_frame();
			frame_no++;
			expect_status(1'b1, frame_no);
			check_flag("irq after status read", irq, 1'b0);
			for (int lane = 0; lane < NUM_LANES; lane++) begin
				read_lane(lane, cnt);
				observed_q.push_back(cnt);
			end
		end
		while (frames_compared < RAND_FRAMES) begin
			next_cycle();
		end

		// second frame is high over the whole window.
		line_in = sample_t'(1);
		wb_write(REG_WINDOW, wb_data_t'(SAT_WINDOW));
		repeat (2) begin
			wait_frame();
			frame_no++;
			expect_status(1'b1, frame_no);
		end
		line_in = '0;
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			read_lane(lane, cnt);
			check_count($sformatf("saturated lane %0d", lane), cnt,
				(lane < `XCORR_MAX_LAG) ? count_t'(255) : count_t'(0));
		end

		wb_write(REG_CTRL, wb_data_t'(0));
		repeat (3 * SAT_WINDOW) begin
			next_cycle();
			check_flag("irq while disabled", irq, 1'b0);
		end
		expect_status(1'b0, frame_no);

		$display("STATUS: PASS");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		abort_run($sformatf("timeout: run not finished after %0d cycles", WATCHDOG_CYCLES));
	end

endmodule
